/* hdl/fu_alu_defs.svh */
// ================================================
// Integer lane widths and latencies
// Word and tag widths, multiplier depth and the
// logic function select codes of the ALU.
// ================================================
`ifndef FU_ALU_DEFS_SVH
`define FU_ALU_DEFS_SVH

`define FU_WORD_W     64
`define FU_TAG_W      4
`define FU_MUL_STAGES 3

// ================================================
// log_sel encodings
// ================================================
`define FU_LOG_AND   2'd0
`define FU_LOG_OR    2'd1
`define FU_LOG_XOR   2'd2
`define FU_LOG_ARITH 2'd3  // Adder output.

`endif

/* hdl/fu_alu_pkg.sv */
// ================================================
// Integer lane types
// Vector types, opcode and operand source enums,
// and the structs carried between the lane blocks.
// ================================================
`include "fu_alu_defs.svh"

package fu_alu_pkg;

  typedef logic [`FU_WORD_W-1:0] word_t;
  typedef logic [`FU_TAG_W-1:0]  tag_t;
  typedef logic [3:0]            flags_t;  // {zero, carry, sign, overflow}.

  typedef enum logic [3:0] {
    op_add    = 4'd0,
    op_sub    = 4'd1,
    op_and    = 4'd2,
    op_or     = 4'd3,
    op_xor    = 4'd4,
    op_shl    = 4'd5,
    op_shr    = 4'd6,
    op_sar    = 4'd7,
    op_mul_lo = 4'd8,
    op_mul_hi = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    src_issue = 2'd0,
    src_alu   = 2'd1,
    src_ext   = 2'd2
  } src_sel_e;

  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    tag_t     tag;
    word_t    a;
    word_t    b;
    src_sel_e src_a;
    src_sel_e src_b;
  } issue_t;

  typedef struct packed {
    logic       valid;
    tag_t       tag;
    logic       is_sub;
    logic [1:0] log_sel;
    logic       is_shift;
    logic       shift_arith;
    logic       shift_right;
    logic       res_shift;
  } exec_ctrl_t;

  typedef struct packed {
    logic   valid;
    tag_t   tag;
    word_t  res;
    flags_t flags;
  } result_t;

endpackage

/* hdl/alu_ctrl.sv */
// ================================================
// Lane control
// Decodes the issued opcode into registered ALU
// controls and multiplier enables.
// ================================================
`timescale 1ns/1ps
`include "fu_alu_defs.svh"

module alu_ctrl
  import fu_alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_valid,
  input  alu_op_e    issue_op,
  input  tag_t       issue_tag,
  output exec_ctrl_t exec_ctrl,
  output logic       mul_en,
  output logic       mul_hi,
  output tag_t       mul_tag
);

  exec_ctrl_t dec;
  logic       is_mul;

  // ================================================
  // Opcode decode
  // ================================================
  always_comb begin
    dec         = '0;
    dec.tag     = issue_tag;
    dec.log_sel = `FU_LOG_ARITH;
    case (issue_op)
      op_sub: dec.is_sub = 1'b1;
      op_and: dec.log_sel = `FU_LOG_AND;
      op_or:  dec.log_sel = `FU_LOG_OR;
      op_xor: dec.log_sel = `FU_LOG_XOR;
      op_shl: begin
        dec.is_shift  = 1'b1;
        dec.res_shift = 1'b1;
      end
      op_shr: begin
        dec.is_shift    = 1'b1;
        dec.shift_right = 1'b1;
        dec.res_shift   = 1'b1;
      end
      op_sar: begin
        dec.is_shift    = 1'b1;
        dec.shift_right = 1'b1;
        dec.shift_arith = 1'b1;  // Sign fill.
        dec.res_shift   = 1'b1;
      end
      default: dec.is_sub = 1'b0;  // Add and multiplies.
    endcase
    is_mul    = (issue_op == op_mul_lo) || (issue_op == op_mul_hi);
    dec.valid = issue_valid && !is_mul;  // Either ALU or multiplier.
  end

  // ================================================
  // Issue stage registers
  // ================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      exec_ctrl.valid <= 1'b0;
      mul_en          <= 1'b0;
    end else begin
      exec_ctrl <= dec;
      mul_en    <= issue_valid && is_mul;
      mul_hi    <= issue_op == op_mul_hi;
      mul_tag   <= issue_tag;
    end
  end

endmodule

/* hdl/operand_fwd.sv */
// ================================================
// Operand forwarding
// Picks each operand from the issue, the lane's own
// result or the external bus, then registers it.
// ================================================
`timescale 1ns/1ps

module operand_fwd
  import fu_alu_pkg::*;
(
  input  logic     clk,
  input  word_t    a_in,
  input  word_t    b_in,
  input  src_sel_e src_a,
  input  src_sel_e src_b,
  input  word_t    alu_fb,
  input  word_t    ext_res,
  output word_t    opnd_a,
  output word_t    opnd_b
);

  word_t a_sel;
  word_t b_sel;

  // Bypass mux shared by both operands.
  function automatic word_t fwd_pick(
    input src_sel_e sel,
    input word_t    issued,
    input word_t    own,
    input word_t    ext
  );
    case (sel)
      src_alu: fwd_pick = own;
      src_ext: fwd_pick = ext;
      default: fwd_pick = issued;
    endcase
  endfunction

  always_comb begin
    a_sel = fwd_pick(src_a, a_in, alu_fb, ext_res);
    b_sel = fwd_pick(src_b, b_in, alu_fb, ext_res);
  end

  // Operand pipeline registers, aligned with the decoded controls.
  always_ff @(posedge clk) begin
    opnd_a <= a_sel;
    opnd_b <= b_sel;
  end

endmodule

/* hdl/alu_exec.sv */
// ================================================
// ALU execute stage
// Add/sub, logic and barrel shift with flags, and
// the registered result of the lane.
// ================================================
`timescale 1ns/1ps
`include "fu_alu_defs.svh"

module alu_exec
  import fu_alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  exec_ctrl_t exec_ctrl,
  input  word_t      opnd_a,
  input  word_t      opnd_b,
  output result_t    alu_out,
  output word_t      alu_fb
);

  localparam int W    = `FU_WORD_W;
  localparam int SH_W = $clog2(W);

  word_t           b_eff;
  logic [W:0]      sum_full;
  word_t           sum;
  logic            carry;
  logic            ovf;
  word_t           logic_res;
  word_t           shift_in;
  logic [SH_W-1:0] shamt;
  logic [2*W-1:0]  right_ext;
  word_t           shift_res;
  word_t           res;
  logic            arith_sel;

  // ================================================
  // Adder
  // ================================================
  always_comb begin
    b_eff    = exec_ctrl.is_sub ? ~opnd_b : opnd_b;  // a + ~b + 1 on sub.
    sum_full = {1'b0, opnd_a} + {1'b0, b_eff} + {{W{1'b0}}, exec_ctrl.is_sub};
    sum      = sum_full[W-1:0];
    carry    = sum_full[W] ^ exec_ctrl.is_sub;  // Borrow when a < b.
    ovf      = (opnd_a[W-1] == b_eff[W-1]) && (sum[W-1] != opnd_a[W-1]);
  end

  // ================================================
  // Logic unit and shifter
  // ================================================
  always_comb begin
    case (exec_ctrl.log_sel)
      `FU_LOG_AND: logic_res = opnd_a & opnd_b;
      `FU_LOG_OR:  logic_res = opnd_a | opnd_b;
      `FU_LOG_XOR: logic_res = opnd_a ^ opnd_b;
      default:     logic_res = sum;
    endcase

    // Shifter inputs held at zero unless a shift is issued.
    shift_in  = exec_ctrl.is_shift ? opnd_a : '0;
    shamt     = exec_ctrl.is_shift ? opnd_b[SH_W-1:0] : '0;
    right_ext = {{W{exec_ctrl.shift_arith & shift_in[W-1]}}, shift_in} >> shamt;
    shift_res = exec_ctrl.shift_right ? right_ext[W-1:0] : (shift_in << shamt);

    res       = exec_ctrl.res_shift ? shift_res : logic_res;
    arith_sel = !exec_ctrl.res_shift && (exec_ctrl.log_sel == `FU_LOG_ARITH);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_out.valid <= 1'b0;
    end else begin
      alu_out.valid <= exec_ctrl.valid;
      alu_out.tag   <= exec_ctrl.tag;
      alu_out.res   <= res;
      alu_out.flags <= {res == '0, arith_sel & carry, res[W-1], arith_sel & ovf};
    end
  end

  assign alu_fb = alu_out.res;  // Same cycle as the result port.

endmodule

/* hdl/mul_pipe.sv */
// ================================================
// Pipelined multiplier
// Unsigned 64x64 product over three stages, with
// the low or high half on its own result port.
// ================================================
`timescale 1ns/1ps
`include "fu_alu_defs.svh"

module mul_pipe
  import fu_alu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    mul_en,
  input  logic    mul_hi,
  input  tag_t    mul_tag,
  input  word_t   opnd_a,
  input  word_t   opnd_b,
  output result_t mul_out
);

  localparam int W   = `FU_WORD_W;
  localparam int HW  = W / 2;
  localparam int P_W = 2 * W;
  localparam int NS  = `FU_MUL_STAGES;

  logic [NS-1:0]  vld_q;
  logic [NS-2:0]  hi_q;
  tag_t           tag_q [NS];
  word_t          pp_ll, pp_lh, pp_hl, pp_hh;
  logic [P_W-1:0] prod_q;
  word_t          res_q;

  always_ff @(posedge clk) begin
    if (rst) vld_q <= '0;
    else     vld_q <= {vld_q[NS-2:0], mul_en};
  end

  always_ff @(posedge clk) begin
    hi_q     <= {hi_q[NS-3:0], mul_hi};
    tag_q[0] <= mul_tag;
    for (int i = 1; i < NS; i++) tag_q[i] <= tag_q[i-1];

    // Stage 1, 32x32 partial products.
    pp_ll <= W'(opnd_a[HW-1:0]) * W'(opnd_b[HW-1:0]);
    pp_lh <= W'(opnd_a[HW-1:0]) * W'(opnd_b[W-1:HW]);
    pp_hl <= W'(opnd_a[W-1:HW]) * W'(opnd_b[HW-1:0]);
    pp_hh <= W'(opnd_a[W-1:HW]) * W'(opnd_b[W-1:HW]);
    // Stage 2, full product.
    prod_q <= {pp_hh, pp_ll} + (P_W'(pp_lh) << HW) + (P_W'(pp_hl) << HW);
    // Stage 3, half select.
    res_q <= hi_q[NS-2] ? prod_q[P_W-1:W] : prod_q[W-1:0];
  end

  assign mul_out = '{valid: vld_q[NS-1], tag: tag_q[NS-1], res: res_q,
                     flags: {res_q == '0, 1'b0, res_q[W-1], 1'b0}};

endmodule

/* hdl/fu_alu_top.sv */
// ================================================
// Integer execution lane
// Control, forwarding, ALU and multiplier of one
// lane, with separate ALU and multiplier ports.
// ================================================
`timescale 1ns/1ps

module fu_alu_top
  import fu_alu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  issue_t  issue,
  input  word_t   ext_res,
  output result_t alu_out,
  output result_t mul_out
);

  exec_ctrl_t exec_ctrl;
  logic       mul_en;
  logic       mul_hi;
  tag_t       mul_tag;
  word_t      opnd_a;
  word_t      opnd_b;
  word_t      alu_fb;

  alu_ctrl alu_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue.valid),
    .issue_op    (issue.op),
    .issue_tag   (issue.tag),
    .exec_ctrl   (exec_ctrl),
    .mul_en      (mul_en),
    .mul_hi      (mul_hi),
    .mul_tag     (mul_tag)
  );

  operand_fwd operand_fwd_i (
    .clk     (clk),
    .a_in    (issue.a),
    .b_in    (issue.b),
    .src_a   (issue.src_a),
    .src_b   (issue.src_b),
    .alu_fb  (alu_fb),
    .ext_res (ext_res),
    .opnd_a  (opnd_a),
    .opnd_b  (opnd_b)
  );

  alu_exec alu_exec_i (
    .clk       (clk),
    .rst       (rst),
    .exec_ctrl (exec_ctrl),
    .opnd_a    (opnd_a),
    .opnd_b    (opnd_b),
    .alu_out   (alu_out),
    .alu_fb    (alu_fb)
  );

  // Multiplier shares the forwarded operands.
  mul_pipe mul_pipe_i (
    .clk     (clk),
    .rst     (rst),
    .mul_en  (mul_en),
    .mul_hi  (mul_hi),
    .mul_tag (mul_tag),
    .opnd_a  (opnd_a),
    .opnd_b  (opnd_b),
    .mul_out (mul_out)
  );

endmodule

/* tb/fu_alu_assertions.sv */
// ================================================
// Lane assertions
// Result latency, result sources and reset
// behavior of the integer lane.
// ================================================
`timescale 1ns/1ps
`include "fu_alu_defs.svh"

module fu_alu_assertions
  import fu_alu_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input issue_t     issue,
  input exec_ctrl_t exec_ctrl,
  input logic       mul_en,
  input result_t    alu_out,
  input result_t    mul_out
);

  localparam int MUL_LAT = `FU_MUL_STAGES + 1;

  logic mul_issue;
  logic alu_issue;

  assign mul_issue = issue.valid && (issue.op == op_mul_lo || issue.op == op_mul_hi);
  assign alu_issue = issue.valid && !mul_issue;

  a_alu_lat: assert property (@(posedge clk) disable iff (rst) alu_issue |-> ##2 alu_out.valid)
    else $error("ALU result missing two cycles after its issue");

  a_alu_src: assert property (@(posedge clk) disable iff (rst)
    alu_out.valid |-> $past(alu_issue, 2))
    else $error("ALU result valid without a matching issue");

  a_mul_lat: assert property (@(posedge clk) disable iff (rst)
    mul_issue |-> ##MUL_LAT mul_out.valid)
    else $error("multiplier result missing after its pipeline latency");

  a_mul_src: assert property (@(posedge clk) disable iff (rst)
    mul_out.valid |-> $past(mul_issue, MUL_LAT))
    else $error("multiplier result valid without a matching issue");

  a_reset: assert property (@(posedge clk)
    rst |=> !alu_out.valid && !mul_out.valid && !exec_ctrl.valid && !mul_en)
    else $error("valid signals high after reset");

endmodule

/* tb/fu_alu_tb.sv */
// ================================================
// Integer lane testbench
// Directed and random issues checked against a
// reference model, with forwarding tracked here.
// ================================================
`timescale 1ns/1ps
`include "fu_alu_defs.svh"

module fu_alu_tb
  import fu_alu_pkg::*;
();

  localparam int ALU_LAT     = 2;
  localparam int MUL_LAT     = `FU_MUL_STAGES + 1;
  localparam int DRAIN_LIMIT = 40;

  typedef struct packed {
    word_t  res;
    flags_t flags;
  } ref_t;

  typedef struct packed {
    tag_t        tag;
    word_t       res;
    flags_t      flags;
    logic [31:0] due;  // Cycle count at which the result shows.
  } exp_t;

  logic    clk;
  logic    rst;
  issue_t  issue;
  word_t   ext_res;
  result_t alu_out;
  result_t mul_out;

  exp_t       alu_q[$];
  exp_t       mul_q[$];
  int         cyc = 0;
  int         checks = 0;
  int         errors = 0;
  int         test_checks = 0;
  int         test_errors = 0;
  bit         timed_out = 1'b0;
  logic [1:0] hist_vld;  // ALU port history, index 0 is the last drive.
  word_t      hist_res [2];
  tag_t       next_tag;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  fu_alu_top fu_alu_top_i (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .ext_res (ext_res),
    .alu_out (alu_out),
    .mul_out (mul_out)
  );

  bind fu_alu_top fu_alu_assertions fu_alu_assertions_i (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .exec_ctrl (exec_ctrl),
    .mul_en    (mul_en),
    .alu_out   (alu_out),
    .mul_out   (mul_out)
  );

  // ================================================
  // Reference model
  // ================================================
  function automatic ref_t ref_model(input alu_op_e op, input word_t a, input word_t b);
    ref_t         r;
    logic [64:0]  wide;
    logic [127:0] prod;
    logic [5:0]   sh;
    logic         c;
    logic         v;
    sh   = b[5:0];
    c    = 1'b0;
    v    = 1'b0;
    prod = {64'd0, a} * {64'd0, b};
    case (op)
      op_add: begin
        wide  = {1'b0, a} + {1'b0, b};
        r.res = wide[63:0];
        c     = wide[64];
        v     = (a[63] == b[63]) && (r.res[63] != a[63]);
      end
      op_sub: begin
        r.res = a - b;
        c     = a < b;  // Borrow.
        v     = (a[63] != b[63]) && (r.res[63] != a[63]);
      end
      op_and:    r.res = a & b;
      op_or:     r.res = a | b;
      op_xor:    r.res = a ^ b;
      op_shl:    r.res = a << sh;
      op_shr:    r.res = a >> sh;
      op_sar:    r.res = $signed(a) >>> sh;
      op_mul_lo: r.res = prod[63:0];
      default:   r.res = prod[127:64];
    endcase
    r.flags = {r.res == '0, c, r.res[63], v};
    return r;
  endfunction

  function automatic word_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  function automatic src_sel_e rand_src(input bit alu_ok);
    logic [1:0] s;
    s = 2'($urandom_range(0, 2));
    if (s == 2'd1 && !alu_ok) s = 2'd0;  // Port holds no valid result.
    return src_sel_e'(s);
  endfunction

  // ================================================
  // Drivers
  // ================================================
  task automatic send_op(input alu_op_e op, input word_t a, input word_t b,
                         input src_sel_e sa, input src_sel_e sb, input word_t ext);
    issue_t nxt;
    word_t  opa;
    word_t  opb;
    ref_t   r;
    exp_t   e;
    bit     is_mul;
    @(posedge clk);
    is_mul = (op == op_mul_lo) || (op == op_mul_hi);
    if ((sa == src_alu || sb == src_alu) && !hist_vld[1]) begin
      $display("forwarding from alu_out at %0t while no valid ALU result is there", $time);
      errors++;
    end
    opa = (sa == src_alu) ? hist_res[1] : (sa == src_ext) ? ext : a;
    opb = (sb == src_alu) ? hist_res[1] : (sb == src_ext) ? ext : b;
    r   = ref_model(op, opa, opb);
    nxt.valid = 1'b1;
    nxt.op    = op;
    nxt.tag   = next_tag;
    nxt.a     = a;
    nxt.b     = b;
    nxt.src_a = sa;
    nxt.src_b = sb;
    issue   <= nxt;
    ext_res <= ext;
    e.tag   = next_tag;
    e.res   = r.res;
    e.flags = r.flags;
    e.due   = 32'(cyc + 1 + (is_mul ? MUL_LAT : ALU_LAT));
    if (is_mul) mul_q.push_back(e);
    else        alu_q.push_back(e);
    hist_vld[1] = hist_vld[0];
    hist_res[1] = hist_res[0];
    hist_vld[0] = !is_mul;
    hist_res[0] = r.res;
    next_tag    = next_tag + 1'b1;
  endtask

  task automatic send_plain(input alu_op_e op, input word_t a, input word_t b);
    send_op(op, a, b, src_issue, src_issue, rand_word());
  endtask

  task automatic send_bubble();
    @(posedge clk);
    issue       <= '0;
    hist_vld[1] = hist_vld[0];
    hist_res[1] = hist_res[0];
    hist_vld[0] = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int n;
    n = 0;
    while ((alu_q.size() != 0 || mul_q.size() != 0) && n < DRAIN_LIMIT) begin
      send_bubble();
      n++;
    end
    if (alu_q.size() != 0 || mul_q.size() != 0) begin
      $display("timeout in %s: %0d ALU and %0d multiplier results never arrived",
               name, alu_q.size(), mul_q.size());
      timed_out = 1'b1;
      errors++;
    end
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  // ================================================
  // Scoreboard
  // ================================================
  task automatic check_result(input string port, input result_t got, input exp_t e);
    checks++;
    assert (got.tag == e.tag) else begin
      $display("mismatch at %0t: %s.tag got %h expected %h", $time, port, got.tag, e.tag);
      errors++;
    end
    assert (got.res == e.res) else begin
      $display("mismatch at %0t: %s.res got %h expected %h", $time, port, got.res, e.res);
      errors++;
    end
    assert (got.flags == e.flags) else begin
      $display("mismatch at %0t: %s.flags got %b expected %b", $time, port, got.flags,
               e.flags);
      errors++;
    end
    assert (cyc == e.due) else begin
      $display("mismatch at %0t: %s arrival cycle got %0d expected %0d", $time, port, cyc,
               e.due);
      errors++;
    end
  endtask

  initial begin : compare
    exp_t e;
    forever begin
      @(negedge clk);
      cyc = cyc + 1;
      if (!rst && alu_out.valid) begin
        if (alu_q.size() == 0) begin
          $display("alu_out.valid high at %0t with no ALU result expected", $time);
          errors++;
        end else begin
          e = alu_q.pop_front();
          check_result("alu_out", alu_out, e);
        end
      end
      if (!rst && mul_out.valid) begin
        if (mul_q.size() == 0) begin
          $display("mul_out.valid high at %0t with no multiply expected", $time);
          errors++;
        end else begin
          e = mul_q.pop_front();
          check_result("mul_out", mul_out, e);
        end
      end
    end
  end

  // ================================================
  // Tests
  // ================================================
  task automatic test_idle();
    repeat (8) begin
      send_bubble();
      @(negedge clk);
      checks++;
      assert (!alu_out.valid && !mul_out.valid) else begin
        $display("a result valid went high at %0t while nothing was issued", $time);
        errors++;
      end
    end
  endtask

  task automatic test_add_sub();
    word_t a;
    word_t b;
    send_plain(op_add, 64'd1, 64'd1);
    send_plain(op_add, '1, 64'd1);  // Carry out and zero.
    send_plain(op_add, 64'h7fff_ffff_ffff_ffff, 64'd1);
    send_plain(op_sub, 64'd5, 64'd5);
    send_plain(op_sub, 64'd3, 64'd5);  // Borrow.
    send_plain(op_sub, 64'h8000_0000_0000_0000, 64'd1);
    for (int i = 0; i < 40; i++) begin
      a = rand_word();
      b = ($urandom_range(0, 7) == 0) ? a : rand_word();
      send_plain(($urandom_range(0, 1) == 1) ? op_sub : op_add, a, b);
    end
  endtask

  task automatic test_logic_shift();
    alu_op_e op;
    word_t   b;
    send_plain(op_shl, rand_word(), 64'd0);
    send_plain(op_shr, '1, 64'd63);
    send_plain(op_sar, 64'h8000_0000_0000_0000, 64'd63);
    for (int i = 0; i < 48; i++) begin
      op      = alu_op_e'(4'($urandom_range(2, 7)));
      b       = rand_word();
      b[5:0]  = 6'($urandom_range(0, 63));
      send_plain(op, rand_word(), b);
    end
  endtask

  task automatic test_mul();
    alu_op_e op;
    send_plain(op_mul_lo, '1, '1);
    send_plain(op_mul_hi, '1, '1);
    send_plain(op_mul_hi, 64'd0, rand_word());
    for (int i = 0; i < 24; i++)
      send_plain(($urandom_range(0, 1) == 1) ? op_mul_hi : op_mul_lo, rand_word(), rand_word());
    for (int i = 0; i < 40; i++) begin
      op = alu_op_e'(4'($urandom_range(0, 9)));
      send_plain(op, rand_word(), rand_word());
    end
  endtask

  task automatic test_forward();
    alu_op_e op;
    src_sel_e sa;
    send_plain(op_add, 64'd10, 64'd20);
    send_plain(op_xor, 64'hff, 64'h0f);
    send_op(op_sub, '0, 64'd5, src_alu, src_issue, rand_word());
    send_op(op_add, '0, 64'd1, src_alu, src_issue, rand_word());
    send_op(op_shl, '0, '0, src_alu, src_alu, rand_word());
    send_op(op_or, 64'd123, '0, src_issue, src_ext, 64'hdead_beef);
    send_op(op_mul_lo, '0, '0, src_ext, src_ext, 64'h1_0000_0003);
    for (int i = 0; i < 60; i++) begin
      op = alu_op_e'(4'($urandom_range(0, 9)));
      sa = rand_src(hist_vld[1]);  // Port entry when this issue is sampled.
      send_op(op, rand_word(), rand_word(), sa, rand_src(hist_vld[1]), rand_word());
    end
  endtask

  initial begin : main
    void'($urandom(32'h5be4_0f0d));
    rst         = 1'b1;
    issue       = '0;
    ext_res     = '0;
    hist_vld    = '0;
    hist_res[0] = '0;
    hist_res[1] = '0;
    next_tag    = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_idle();
    finish_test("reset_idle");
    if (!timed_out) begin
      test_add_sub();
      finish_test("add_sub");
    end
    if (!timed_out) begin
      test_logic_shift();
      finish_test("logic_shift");
    end
    if (!timed_out) begin
      test_mul();
      finish_test("multiply");
    end
    if (!timed_out) begin
      test_forward();
      finish_test("forwarding");
    end
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/fu_alu_pkg.sv
hdl/alu_ctrl.sv
hdl/operand_fwd.sv
hdl/alu_exec.sv
hdl/mul_pipe.sv
hdl/fu_alu_top.sv
tb/fu_alu_assertions.sv
tb/fu_alu_tb.sv

/* Makefile */
# Verilator build and run for the integer lane testbench.

VERILATOR ?= verilator
TOP       ?= fu_alu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
